// File: build.f
+incdir+common
common/xr_mem_pkg.sv
source/xr_dpram.sv
color/xr_color_mem.sv
tile/xr_tile_mem.sv
source/xr_arb.sv
source/xr_mem_top.sv
verification/xr_mem_chk.sv
verification/xr_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the xr memory testbench with verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module xr_mem_tb \
    --Mdir obj_dir -o xr_mem_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/xr_mem_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// File: verification/xr_mem_tb.sv
// testbench for the xr memory block with directed host and video accesses checked against a model

`default_nettype none
`timescale 1ns/1ps

`include "xr_mem_config.svh"

module xr_mem_tb;

    import xr_mem_pkg::*;

    localparam int    TIMEOUT = 64;
    localparam addr_t BANK_B  = addr_t'(1 << `XR_COLOR_W);
    localparam addr_t TILE2   = addr_t'(1 << (`XR_TILE_W - 1));
    localparam addr_t ALIAS   = addr_t'(1 << `XR_TILE2_W);

    logic         clk = 1'b0;
    logic         rst_n_i;
    xr_host_req_t host_req_i;
    word_t        host_data_o;
    logic         host_ack_o;
    logic         xreg_wr_o;
    logic [6:0]   xreg_addr_o;
    word_t        xreg_data_o;
    word_t        xreg_data_i;
    logic         vgen_color_sel_i;
    color_addr_t  vgen_color_a_addr_i;
    color_addr_t  vgen_color_b_addr_i;
    word_t        vgen_color_a_data_o;
    word_t        vgen_color_b_data_o;
    logic         vgen_tile_sel_i;
    tile_addr_t   vgen_tile_addr_i;
    word_t        vgen_tile_data_o;

    // external register file and the expected contents of it and of every bank
    word_t regs          [0:127];
    word_t exp_regs      [0:127];
    word_t exp_color_a   [0:(1 << `XR_COLOR_W)-1];
    word_t exp_color_b   [0:(1 << `XR_COLOR_W)-1];
    word_t exp_tile_main [0:(1 << (`XR_TILE_W - 1))-1];
    word_t exp_tile_2nd  [0:(1 << `XR_TILE2_W)-1];

    logic [31:0] lfsr = 32'h505c;
    int          errors = 0;
    int          checks = 0;
    int          test_start_errors = 0;

    event        timeout_ev;
    string       timeout_what;

    xr_mem_top i_dut (.*);

    always #4 clk = ~clk;

    function automatic word_t reg_fill(input int i);
        return word_t'(i * 263 + 16'h3c5a);
    endfunction

    assign xreg_data_i = regs[xreg_addr_o];

    always @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 128; i++) begin
                regs[i] <= reg_fill(i);
            end
        end else if (xreg_wr_o) begin
            regs[xreg_addr_o] <= xreg_data_o;
        end
    end

    // taps of x^32 + x^22 + x^2 + x + 1 with one step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic model_write(input addr_t a, input word_t d);
        if (!a[15]) begin
            exp_regs[a[6:0]] = d;
        end else if (a[15:13] == 3'b100) begin
            if (!a[`XR_COLOR_W]) begin
                exp_color_a[a[`XR_COLOR_W-1:0]] = d;
            end else if (`XR_EN_PF_B != 0) begin
                exp_color_b[a[`XR_COLOR_W-1:0]] = d;
            end
        end else if (a[15:13] == 3'b101) begin
            // second bank only decodes its low bits
            if (a[`XR_TILE_W-1]) begin
                exp_tile_2nd[a[`XR_TILE2_W-1:0]] = d;
            end else begin
                exp_tile_main[a[`XR_TILE_W-2:0]] = d;
            end
        end
    endtask

    function automatic word_t model_read(input addr_t a);
        word_t v;
        v = '0;
        if (!a[15]) begin
            v = exp_regs[a[6:0]];
        end else if (a[15:13] == 3'b100) begin
            if (!a[`XR_COLOR_W]) begin
                v = exp_color_a[a[`XR_COLOR_W-1:0]];
            end else if (`XR_EN_PF_B != 0) begin
                v = exp_color_b[a[`XR_COLOR_W-1:0]];
            end
        end else if (a[15:13] == 3'b101) begin
            if (a[`XR_TILE_W-1]) begin
                v = exp_tile_2nd[a[`XR_TILE2_W-1:0]];
            end else begin
                v = exp_tile_main[a[`XR_TILE_W-2:0]];
            end
        end
        return v;
    endfunction

    task automatic check_value(input string name, input addr_t a, input word_t got,
                               input word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %s at %h: got %h, expected %h", name, a, got, exp);
            errors++;
        end
    endtask

    // ends the run when a wait loop gives up
    initial begin
        @(timeout_ev);
        $display("timeout at %0t while waiting for %s", $time, timeout_what);
        $display("TEST FAIL");
        $finish;
    end

    task automatic timeout_abort(input string what);
        timeout_what = what;
        -> timeout_ev;
        // the waiting process stays parked until the run ends
        @(timeout_ev);
    endtask

    // counts clock cycles from the request until ack shows at a falling edge
    task automatic wait_ack(output int cycles);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end while (!host_ack_o && cycles < TIMEOUT);
        if (!host_ack_o) begin
            timeout_abort("the host acknowledge");
        end
    endtask

    task automatic host_write(input addr_t a, input word_t d);
        int cycles;
        @(posedge clk);
        #1;
        host_req_i = '{sel: 1'b1, wr: 1'b1, addr: a, data: d};
        wait_ack(cycles);
        check_value("host_ack_o write latency", a, word_t'(cycles), 16'h0001);
        model_write(a, d);
        @(posedge clk);
        #1;
        host_req_i.sel = 1'b0;
    endtask

    task automatic host_read(input addr_t a, output word_t d, output int cycles);
        @(posedge clk);
        #1;
        host_req_i = '{sel: 1'b1, wr: 1'b0, addr: a, data: 16'h0000};
        wait_ack(cycles);
        d = host_data_o;
        @(posedge clk);
        #1;
        host_req_i.sel = 1'b0;
    endtask

    task automatic check_read(input addr_t a);
        word_t d;
        int    cycles;
        host_read(a, d, cycles);
        check_value("host_ack_o read latency", a, word_t'(cycles), 16'h0001);
        check_value("host_data_o", a, d, model_read(a));
    endtask

    // colour and tile lookups together with data due one cycle after the address
    task automatic video_read(input color_addr_t ia, input color_addr_t ib,
                              input tile_addr_t it);
        int waited;
        waited = 0;
        while (host_ack_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (host_ack_o) begin
            timeout_abort("the host acknowledge to clear");
        end
        @(posedge clk);
        #1;
        vgen_color_sel_i    = 1'b1;
        vgen_color_a_addr_i = ia;
        vgen_color_b_addr_i = ib;
        vgen_tile_sel_i     = 1'b1;
        vgen_tile_addr_i    = it;
        @(posedge clk);
        @(negedge clk);
        check_value("vgen_color_a_data_o", 16'h8000 | addr_t'(ia), vgen_color_a_data_o,
                    model_read(16'h8000 | addr_t'(ia)));
        check_value("vgen_color_b_data_o", 16'h8000 | BANK_B | addr_t'(ib),
                    vgen_color_b_data_o, model_read(16'h8000 | BANK_B | addr_t'(ib)));
        check_value("vgen_tile_data_o", 16'hA000 | addr_t'(it), vgen_tile_data_o,
                    model_read(16'hA000 | addr_t'(it)));
        @(posedge clk);
        #1;
        vgen_color_sel_i = 1'b0;
        vgen_tile_sel_i  = 1'b0;
    endtask

    task automatic report_test(input string name);
        $display("%-14s %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    task automatic test_registers();
        addr_t a [8];
        for (int i = 0; i < 8; i++) begin
            a[i] = rand_bits(7);
            host_write(a[i], rand_bits(16));
        end
        for (int i = 0; i < 8; i++) begin
            check_read(a[i]);
        end
        report_test("registers");
    endtask

    task automatic test_color();
        addr_t a;
        for (int i = 0; i < 8; i++) begin
            a = 16'h8000 | rand_bits(`XR_COLOR_W);
            host_write(a, rand_bits(16));
            host_write(a | BANK_B, rand_bits(16));
            check_read(a);
            check_read(a | BANK_B);
        end
        report_test("colour banks");
    endtask

    task automatic test_tile();
        addr_t main_a;
        addr_t second_a;
        for (int i = 0; i < 6; i++) begin
            main_a   = 16'hA000 | rand_bits(`XR_TILE_W - 1);
            second_a = 16'hA000 | TILE2 | rand_bits(`XR_TILE2_W);
            host_write(main_a, rand_bits(16));
            host_write(second_a, rand_bits(16));
            check_read(main_a);
            check_read(second_a);
            // upper half of the second bank range mirrors the lower half
            check_read(second_a | ALIAS);
        end
        host_write(16'hA000 | (TILE2 - 16'd1), rand_bits(16));
        host_write(16'hA000 | TILE2, rand_bits(16));
        check_read(16'hA000 | (TILE2 - 16'd1));
        check_read(16'hA000 | TILE2);
        report_test("tile banks");
    endtask

    task automatic test_video();
        color_addr_t ia;
        color_addr_t ib;
        tile_addr_t  it;
        for (int i = 0; i < 6; i++) begin
            ia = color_addr_t'(rand_bits(`XR_COLOR_W));
            ib = color_addr_t'(rand_bits(`XR_COLOR_W));
            it = tile_addr_t'(rand_bits(`XR_TILE_W));
            host_write(16'h8000 | addr_t'(ia), rand_bits(16));
            host_write(16'h8000 | BANK_B | addr_t'(ib), rand_bits(16));
            host_write(16'hA000 | addr_t'(it), rand_bits(16));
            video_read(ia, ib, it);
        end
        report_test("video reads");
    endtask

    task automatic test_backpressure();
        addr_t a;
        word_t d;
        int    cycles;
        a = 16'h8000 | rand_bits(`XR_COLOR_W);
        host_write(a, rand_bits(16));
        @(posedge clk);
        #1;
        vgen_color_sel_i = 1'b1;
        fork
            host_read(a, d, cycles);
            begin
                repeat (6) begin
                    @(posedge clk);
                    @(negedge clk);
                    checks++;
                    assert (!host_ack_o) else begin
                        $display("host colour read acknowledged while video held the port");
                        errors++;
                    end
                end
                @(posedge clk);
                #1;
                vgen_color_sel_i = 1'b0;
            end
        join
        // select drops in the seventh cycle, accepted at its end, ack one cycle on
        check_value("host_ack_o read latency", a, word_t'(cycles), 16'h0007);
        check_value("host_data_o", a, d, model_read(a));
        // writes have their own port and see no back-pressure
        @(posedge clk);
        #1;
        vgen_color_sel_i = 1'b1;
        host_write(a, rand_bits(16));
        vgen_color_sel_i = 1'b0;
        check_read(a);
        report_test("back-pressure");
    endtask

    task automatic test_unmapped();
        addr_t k;
        word_t d;
        k = rand_bits(7);
        host_write(k, rand_bits(16));
        host_write(16'h8000 | k, rand_bits(16));
        host_write(16'hA000 | k, rand_bits(16));
        d = rand_bits(16);
        host_write(16'hC000 | k, d);
        host_write(16'hE000 | k, ~d);
        check_read(k);
        check_read(16'h8000 | k);
        check_read(16'hA000 | k);
        check_read(16'hC000 | k);
        check_read(16'hE000 | k);
        for (int i = 0; i < 128; i++) begin
            check_value("register file", addr_t'(i), regs[i], exp_regs[i]);
        end
        report_test("unmapped");
    endtask

    initial begin
        rst_n_i             = 1'b0;
        host_req_i          = '0;
        vgen_color_sel_i    = 1'b0;
        vgen_color_a_addr_i = '0;
        vgen_color_b_addr_i = '0;
        vgen_tile_sel_i     = 1'b0;
        vgen_tile_addr_i    = '0;
        for (int i = 0; i < 128; i++) begin
            exp_regs[i] = reg_fill(i);
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        test_registers();
        test_color();
        test_tile();
        test_video();
        test_backpressure();
        test_unmapped();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/xr_mem_chk.sv
// xr arbiter checker, host acknowledge and register bus handshake rules

`default_nettype none
`timescale 1ns/1ps

module xr_mem_chk (
    input wire logic                     clk,
    input wire logic                     rst_n_i,
    input wire xr_mem_pkg::xr_host_req_t host_req_i,
    input wire logic                     ack_i,
    input wire logic                     xreg_wr_i
);

    // ack is a single cycle pulse
    a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        ack_i |=> !ack_i)
        else $error("host ack high in two consecutive cycles");

    // every ack answers a request selected the cycle before
    a_ack_after_sel: assert property (@(posedge clk) disable iff (!rst_n_i)
        ack_i |-> $past(host_req_i.sel))
        else $error("host ack without a selected request in the previous cycle");

    a_xreg_wr: assert property (@(posedge clk) disable iff (!rst_n_i)
        xreg_wr_i |-> (host_req_i.sel && host_req_i.wr))
        else $error("register bus write without a selected host write");

endmodule

bind xr_arb xr_mem_chk i_chk (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .host_req_i (host_req_i),
    .ack_i      (host_ack_o),
    .xreg_wr_i  (xreg_wr_o)
);

`default_nettype wire

// File: source/xr_mem_top.sv
// xr memory block top, arbiter plus colour and tile memories

`default_nettype none
`timescale 1ns/1ps

module xr_mem_top (
    input  wire logic                      clk,
    input  wire logic                      rst_n_i,
    // host port
    input  wire xr_mem_pkg::xr_host_req_t  host_req_i,
    output xr_mem_pkg::word_t              host_data_o,
    output logic                           host_ack_o,
    // external register bus
    output logic                           xreg_wr_o,
    output logic [6:0]                     xreg_addr_o,
    output xr_mem_pkg::word_t              xreg_data_o,
    input  wire xr_mem_pkg::word_t         xreg_data_i,
    // video colour lookups
    input  wire logic                      vgen_color_sel_i,
    input  wire xr_mem_pkg::color_addr_t   vgen_color_a_addr_i,
    input  wire xr_mem_pkg::color_addr_t   vgen_color_b_addr_i,
    output xr_mem_pkg::word_t              vgen_color_a_data_o,
    output xr_mem_pkg::word_t              vgen_color_b_data_o,
    // video tile reads
    input  wire logic                      vgen_tile_sel_i,
    input  wire xr_mem_pkg::tile_addr_t    vgen_tile_addr_i,
    output xr_mem_pkg::word_t              vgen_tile_data_o
);

    import xr_mem_pkg::*;

    xr_mem_wr_t mem_wr;
    logic       color_rd;
    logic       tile_rd;
    logic       color_busy;
    logic       tile_busy;
    word_t      color_host_data;
    word_t      tile_host_data;

    xr_arb i_arb (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .host_req_i   (host_req_i),
        .host_ack_o   (host_ack_o),
        .host_data_o  (host_data_o),
        .xreg_wr_o    (xreg_wr_o),
        .xreg_addr_o  (xreg_addr_o),
        .xreg_data_o  (xreg_data_o),
        .xreg_data_i  (xreg_data_i),
        .mem_wr_o     (mem_wr),
        .color_rd_o   (color_rd),
        .tile_rd_o    (tile_rd),
        .color_busy_i (color_busy),
        .tile_busy_i  (tile_busy),
        .color_data_i (color_host_data),
        .tile_data_i  (tile_host_data)
    );

    // host read index rides on the broadcast write bus address
    xr_color_mem i_color_mem (
        .clk           (clk),
        .vgen_sel_i    (vgen_color_sel_i),
        .vgen_a_addr_i (vgen_color_a_addr_i),
        .vgen_b_addr_i (vgen_color_b_addr_i),
        .vgen_a_data_o (vgen_color_a_data_o),
        .vgen_b_data_o (vgen_color_b_data_o),
        .host_rd_i     (color_rd),
        .host_addr_i   (mem_wr.addr),
        .host_data_o   (color_host_data),
        .wr_i          (mem_wr),
        .busy_o        (color_busy)
    );

    xr_tile_mem i_tile_mem (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .vgen_sel_i  (vgen_tile_sel_i),
        .vgen_addr_i (vgen_tile_addr_i),
        .vgen_data_o (vgen_tile_data_o),
        .host_rd_i   (tile_rd),
        .host_addr_i (mem_wr.addr),
        .host_data_o (tile_host_data),
        .wr_i        (mem_wr),
        .busy_o      (tile_busy)
    );

endmodule

`default_nettype wire

// File: source/xr_arb.sv
// xr arbiter, decodes host accesses, routes writes, grants memory reads and returns results

`default_nettype none
`timescale 1ns/1ps

module xr_arb (
    input  wire logic                      clk,
    input  wire logic                      rst_n_i,
    input  wire xr_mem_pkg::xr_host_req_t  host_req_i,
    output logic                           host_ack_o,
    output xr_mem_pkg::word_t              host_data_o,
    output logic                           xreg_wr_o,
    output logic [6:0]                     xreg_addr_o,
    output xr_mem_pkg::word_t              xreg_data_o,
    input  wire xr_mem_pkg::word_t         xreg_data_i,
    output xr_mem_pkg::xr_mem_wr_t         mem_wr_o,
    output logic                           color_rd_o,
    output logic                           tile_rd_o,
    input  wire logic                      color_busy_i,
    input  wire logic                      tile_busy_i,
    input  wire xr_mem_pkg::word_t         color_data_i,
    input  wire xr_mem_pkg::word_t         tile_data_i
);

    import xr_mem_pkg::*;

    xr_region_e region;
    xr_region_e region_q;
    logic       req_valid;
    logic       is_wr;
    logic       accept;
    word_t      xreg_data_q;

    // address decode, bit 15 clear is the register bus
    always_comb begin
        if (!host_req_i.addr[15]) begin
            region = XR_REGION_REGS;
        end else if (host_req_i.addr[15:13] == XR_COLOR_TOP) begin
            region = XR_REGION_COLOR;
        end else if (host_req_i.addr[15:13] == XR_TILE_TOP) begin
            region = XR_REGION_TILE;
        end else begin
            region = XR_REGION_NONE;
        end
    end

    // a request seen in the ack cycle is the one just served
    assign req_valid = host_req_i.sel & ~host_ack_o;
    assign is_wr     = host_req_i.wr;

    // memory reads wait for the video side to release the port
    assign color_rd_o = req_valid & ~is_wr & (region == XR_REGION_COLOR) & ~color_busy_i;
    assign tile_rd_o  = req_valid & ~is_wr & (region == XR_REGION_TILE) & ~tile_busy_i;

    always_comb begin
        accept = 1'b0;
        if (req_valid) begin
            unique case (region)
                XR_REGION_COLOR: accept = is_wr | ~color_busy_i;
                XR_REGION_TILE:  accept = is_wr | ~tile_busy_i;
                default:         accept = 1'b1;
            endcase
        end
    end

    // register bus, reads are combinational from the address
    assign xreg_wr_o   = req_valid & is_wr & (region == XR_REGION_REGS);
    assign xreg_addr_o = host_req_i.addr[6:0];
    assign xreg_data_o = host_req_i.data;

    // memory writes go straight to the separate write ports
    always_comb begin
        mem_wr_o.en   = req_valid & is_wr &
                        ((region == XR_REGION_COLOR) || (region == XR_REGION_TILE));
        mem_wr_o.addr = host_req_i.addr;
        mem_wr_o.data = host_req_i.data;
    end

    // ack one cycle after acceptance
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            host_ack_o <= 1'b0;
            region_q   <= XR_REGION_NONE;
        end else begin
            host_ack_o <= accept;
            if (accept) begin
                region_q <= region;
            end
        end
    end

    // register read result held so it lines up with ack
    always_ff @(posedge clk) begin
        if (accept) begin
            xreg_data_q <= xreg_data_i;
        end
    end

    // read result by the region accepted last cycle
    always_comb begin
        unique case (region_q)
            XR_REGION_REGS:  host_data_o = xreg_data_q;
            XR_REGION_COLOR: host_data_o = color_data_i;
            XR_REGION_TILE:  host_data_o = tile_data_i;
            default:         host_data_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: tile/xr_tile_mem.sv
// tile memory, main and second bank with a registered bank select on the read side

`default_nettype none
`timescale 1ns/1ps

`include "xr_mem_config.svh"

module xr_tile_mem (
    input  wire logic                      clk,
    input  wire logic                      rst_n_i,
    input  wire logic                      vgen_sel_i,
    input  wire xr_mem_pkg::tile_addr_t    vgen_addr_i,
    output xr_mem_pkg::word_t              vgen_data_o,
    input  wire logic                      host_rd_i,
    input  wire xr_mem_pkg::addr_t         host_addr_i,
    output xr_mem_pkg::word_t              host_data_o,
    input  wire xr_mem_pkg::xr_mem_wr_t    wr_i,
    output logic                           busy_o
);

    import xr_mem_pkg::*;

    tile_addr_t rd_addr;
    word_t      main_data;
    word_t      second_data;
    word_t      rd_data;
    logic       wr_tile;
    logic       bank_sel_q;

    assign busy_o  = vgen_sel_i;
    assign rd_addr = vgen_sel_i ? vgen_addr_i : host_addr_i[`XR_TILE_W-1:0];

    // write bus is shared with the colour memory
    assign wr_tile = wr_i.en && (wr_i.addr[15:13] == XR_TILE_TOP);

    // top offset bit follows the read one cycle late, like the ram data
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bank_sel_q <= 1'b0;
        end else if (vgen_sel_i || host_rd_i) begin
            bank_sel_q <= rd_addr[`XR_TILE_W-1];
        end
    end

    xr_dpram #(
        .AWIDTH(`XR_TILE_W-1)
    ) i_main_bank (
        .clk       (clk),
        .rd_addr_i (rd_addr[`XR_TILE_W-2:0]),
        .rd_data_o (main_data),
        .wr_en_i   (wr_tile & ~wr_i.addr[`XR_TILE_W-1]),
        .wr_addr_i (wr_i.addr[`XR_TILE_W-2:0]),
        .wr_data_i (wr_i.data)
    );

    // smaller bank, only the low offset bits reach it
    xr_dpram #(
        .AWIDTH(`XR_TILE2_W)
    ) i_second_bank (
        .clk       (clk),
        .rd_addr_i (rd_addr[`XR_TILE2_W-1:0]),
        .rd_data_o (second_data),
        .wr_en_i   (wr_tile & wr_i.addr[`XR_TILE_W-1]),
        .wr_addr_i (wr_i.addr[`XR_TILE2_W-1:0]),
        .wr_data_i (wr_i.data)
    );

    assign rd_data     = bank_sel_q ? second_data : main_data;
    assign vgen_data_o = rd_data;
    assign host_data_o = rd_data;

endmodule

`default_nettype wire

// File: color/xr_color_mem.sv
// colour lookup memory, playfield a and b banks shared between video and host reads

`default_nettype none
`timescale 1ns/1ps

`include "xr_mem_config.svh"

module xr_color_mem (
    input  wire logic                      clk,
    input  wire logic                      vgen_sel_i,
    input  wire xr_mem_pkg::color_addr_t   vgen_a_addr_i,
    input  wire xr_mem_pkg::color_addr_t   vgen_b_addr_i,
    output xr_mem_pkg::word_t              vgen_a_data_o,
    output xr_mem_pkg::word_t              vgen_b_data_o,
    input  wire logic                      host_rd_i,
    input  wire xr_mem_pkg::addr_t         host_addr_i,
    output xr_mem_pkg::word_t              host_data_o,
    input  wire xr_mem_pkg::xr_mem_wr_t    wr_i,
    output logic                           busy_o
);

    import xr_mem_pkg::*;

    color_addr_t host_idx;
    color_addr_t a_rd_addr;
    word_t       a_data;
    word_t       b_data;
    logic        wr_color;
    logic        host_bank_b;

    // video owns the read port while it selects
    assign busy_o    = vgen_sel_i;
    assign host_idx  = host_addr_i[`XR_COLOR_W-1:0];
    assign a_rd_addr = vgen_sel_i ? vgen_a_addr_i : host_idx;

    // write bus is shared with the tile memory
    assign wr_color = wr_i.en && (wr_i.addr[15:13] == XR_COLOR_TOP);

    // bank of the granted host read, used when its data comes back
    always_ff @(posedge clk) begin
        if (host_rd_i) begin
            host_bank_b <= host_addr_i[`XR_COLOR_W];
        end
    end

    xr_dpram #(
        .AWIDTH(`XR_COLOR_W)
    ) i_bank_a (
        .clk       (clk),
        .rd_addr_i (a_rd_addr),
        .rd_data_o (a_data),
        .wr_en_i   (wr_color & ~wr_i.addr[`XR_COLOR_W]),
        .wr_addr_i (wr_i.addr[`XR_COLOR_W-1:0]),
        .wr_data_i (wr_i.data)
    );

    generate
        if (`XR_EN_PF_B) begin : g_bank_b
            color_addr_t b_rd_addr;

            assign b_rd_addr = vgen_sel_i ? vgen_b_addr_i : host_idx;

            xr_dpram #(
                .AWIDTH(`XR_COLOR_W)
            ) i_bank_b (
                .clk       (clk),
                .rd_addr_i (b_rd_addr),
                .rd_data_o (b_data),
                .wr_en_i   (wr_color & wr_i.addr[`XR_COLOR_W]),
                .wr_addr_i (wr_i.addr[`XR_COLOR_W-1:0]),
                .wr_data_i (wr_i.data)
            );
        end else begin : g_no_bank_b
            assign b_data = '0;
        end
    endgenerate

    assign vgen_a_data_o = a_data;
    assign vgen_b_data_o = b_data;
    assign host_data_o   = host_bank_b ? b_data : a_data;

endmodule

`default_nettype wire

// File: source/xr_dpram.sv
// dual port ram, one synchronous write port and one read port with registered data

`default_nettype none
`timescale 1ns/1ps

module xr_dpram #(
    parameter int AWIDTH = 8
) (
    input  wire logic               clk,
    input  wire logic [AWIDTH-1:0]  rd_addr_i,
    output xr_mem_pkg::word_t       rd_data_o,
    input  wire logic               wr_en_i,
    input  wire logic [AWIDTH-1:0]  wr_addr_i,
    input  wire xr_mem_pkg::word_t  wr_data_i
);

    import xr_mem_pkg::*;

    word_t mem [0:(1 << AWIDTH)-1];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // read data is valid the cycle after the address
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

// File: common/xr_mem_pkg.sv
// xr memory package, shared word, address, region and bus types for the xr memory block

`default_nettype none

`include "xr_mem_config.svh"

package xr_mem_pkg;

    // data word and xr address space
    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;

    // memory indices
    typedef logic [`XR_COLOR_W-1:0] color_addr_t;
    typedef logic [`XR_TILE_W-1:0]  tile_addr_t;

    // top three address bits of the memory regions
    localparam logic [2:0] XR_COLOR_TOP = 3'b100;
    localparam logic [2:0] XR_TILE_TOP  = 3'b101;

    // decoded target of a host access
    typedef enum logic [1:0] {
        XR_REGION_REGS,
        XR_REGION_COLOR,
        XR_REGION_TILE,
        XR_REGION_NONE
    } xr_region_e;

    // host request, held stable until ack
    typedef struct packed {
        logic  sel;
        logic  wr;
        addr_t addr;
        word_t data;
    } xr_host_req_t;

    // memory write bus, en only set for memory regions
    typedef struct packed {
        logic  en;
        addr_t addr;
        word_t data;
    } xr_mem_wr_t;

endpackage

`default_nettype wire

// File: common/xr_mem_config.svh
// xr memory block build configuration, memory widths and optional playfield b bank

`ifndef XR_MEM_CONFIG_SVH
`define XR_MEM_CONFIG_SVH

// colour lookup bank index width, 256 entries per bank
`define XR_COLOR_W      8

// tile offset width over both tile banks
// offset bit 11 clear selects the 2048 word main bank
`define XR_TILE_W       12

// second tile bank address width, 1024 words
// upper half of the second bank range aliases onto the lower half
`define XR_TILE2_W      10

// 1 builds colour bank b
// 0 leaves it out, its reads return zero and its writes are dropped
`define XR_EN_PF_B      1

`endif
